//--- rtl/pipe_cfg_pkg.sv
`default_nettype none

package pipe_cfg_pkg;

    // Front end widths
    localparam int FETCH_WIDTH = 2;
    localparam int DECODE_WIDTH = 2;

    // Instruction queue geometry
    localparam int BUF_DEPTH = 16;
    localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

    // Fetch stops when fewer free entries than this remain,
    // two fetch groups cover the cycle the stall takes to act
    localparam int STALL_FREE_MIN = 2 * FETCH_WIDTH;

    // Datapath
    localparam int XLEN = 32;
    localparam int INSTR_BYTES = 4;
    localparam logic [XLEN-1:0] RESET_PC = '0;

endpackage

`default_nettype wire

//--- rtl/instr_pkg.sv
`default_nettype none

package instr_pkg;

    import pipe_cfg_pkg::*;

    typedef logic [XLEN-1:0] instr_word_t;
    typedef logic [4:0] reg_idx_t;

    // RV32I major opcodes in bits 6..0 of the word
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // Class handed to the backend
    typedef enum logic [2:0] {
        OP_ALU,
        OP_ALUI,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JAL,
        OP_LUI,
        OP_ILLEGAL
    } op_class_e;

    // One fetched instruction with its address
    typedef struct packed {
        logic        valid;
        logic [XLEN-1:0] pc;
        instr_word_t word;
    } slot_t;

    // Decoder output record
    typedef struct packed {
        logic        valid;
        logic [XLEN-1:0] pc;
        op_class_e   op;
        reg_idx_t    rd;
    } decoded_t;

endpackage

`default_nettype wire

//--- rtl/fetch_slot_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_slot_if
    import pipe_cfg_pkg::*;
    import instr_pkg::*;
();

    // Slot 0 is the older instruction
    slot_t slots [FETCH_WIDTH];

    // Same-cycle take mask, always a prefix of the valid slots
    logic [FETCH_WIDTH-1:0] accept;

    // Hold request back to the producer
    logic stall;

    // Drop everything in flight
    logic flush;

    modport src (
        output slots,
        output flush,
        input  accept,
        input  stall
    );

    modport dst (
        input  slots,
        input  flush,
        output accept,
        output stall
    );

endinterface

`default_nettype wire

//--- rtl/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch
    import pipe_cfg_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,

    // Instruction memory
    output logic [XLEN-1:0]                 imem_addr_o,
    input  logic [FETCH_WIDTH-1:0][XLEN-1:0] imem_rdata_i,
    input  logic                            imem_valid_i,

    // Backend restart
    input  logic                            redirect_i,
    input  logic [XLEN-1:0]                 redirect_pc_i,

    // To the instruction buffer
    fetch_slot_if.src                       push
);

    logic [XLEN-1:0] pc_q;
    logic            fetch_fire;

    // A group moves only when memory has it and the buffer has room.
    // Words read in the redirect cycle belong to the old path
    assign fetch_fire = imem_valid_i && !push.stall && !redirect_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (fetch_fire) begin
            pc_q <= pc_q + XLEN'(FETCH_WIDTH * INSTR_BYTES);
        end
    end

    assign imem_addr_o = pc_q;

    // Pack memory words with their own PCs
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            push.slots[i].valid = fetch_fire;
            push.slots[i].pc    = pc_q + XLEN'(i * INSTR_BYTES);
            push.slots[i].word  = imem_rdata_i[i];
        end
    end

    // Redirect flushes everything behind fetch in the same cycle
    assign push.flush = redirect_i;

endmodule

`default_nettype wire

//--- rtl/instr_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module instr_buffer
    import pipe_cfg_pkg::*;
    import instr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // From fetch
    fetch_slot_if.dst push,

    // To decode
    fetch_slot_if.src pop
);

    slot_t                      mem [BUF_DEPTH];
    logic [BUF_PTR_W-1:0]       rd_ptr;
    logic [BUF_PTR_W-1:0]       wr_ptr;
    logic [BUF_PTR_W:0]         count;
    logic [$clog2(FETCH_WIDTH):0] push_num;
    logic [$clog2(FETCH_WIDTH):0] pop_num;
    logic [BUF_PTR_W-1:0]       wr_idx [FETCH_WIDTH];

    // Each valid push slot lands behind the ones before it,
    // so a gap in the valid bits still packs densely
    always_comb begin : push_count
        push_num = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            wr_idx[i] = wr_ptr + BUF_PTR_W'(push_num);
            if (push.slots[i].valid) begin
                push_num = push_num + 1'b1;
            end
        end
    end

    // Popcount of the decoder take mask
    always_comb begin : pop_count
        pop_num = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (pop.accept[i] && pop.slots[i].valid) begin
                pop_num = pop_num + 1'b1;
            end
        end
    end

    // Pointers wrap on their own at BUF_DEPTH
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (push.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + BUF_PTR_W'(push_num);
            rd_ptr <= rd_ptr + BUF_PTR_W'(pop_num);
            count  <= count + (BUF_PTR_W+1)'(push_num) - (BUF_PTR_W+1)'(pop_num);
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (push.slots[i].valid && !push.flush) begin
                mem[wr_idx[i]] <= push.slots[i];
            end
        end
    end

    // Free space check on the registered count only
    assign push.stall = (BUF_DEPTH - int'(count)) < STALL_FREE_MIN;

    // Head entries take their valid bits from occupancy rather than storage
    always_comb begin : head_view
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            pop.slots[i]       = mem[rd_ptr + BUF_PTR_W'(i)];
            pop.slots[i].valid = int'(count) > i;
        end
    end

    assign pop.flush = push.flush;

endmodule

`default_nettype wire

//--- rtl/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import pipe_cfg_pkg::*;
    import instr_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,

    // Head of the instruction buffer
    fetch_slot_if.dst                           pop,
    input  logic                                flush_i,

    // Downstream capacity this cycle
    input  logic [$clog2(DECODE_WIDTH+1)-1:0]   dec_slots_i,

    // Registered decode results
    output logic [DECODE_WIDTH-1:0]             dec_valid_o,
    output logic [DECODE_WIDTH-1:0][XLEN-1:0]   dec_pc_o,
    output op_class_e [DECODE_WIDTH-1:0]        dec_op_o,
    output logic [DECODE_WIDTH-1:0][4:0]        dec_rd_o
);

    decoded_t nxt   [DECODE_WIDTH];
    decoded_t dec_q [DECODE_WIDTH];

    function automatic op_class_e classify(input logic [6:0] opc);
        op_class_e cls;
        case (opcode_e'(opc))
            OPC_OP:     cls = OP_ALU;
            OPC_OP_IMM: cls = OP_ALUI;
            OPC_LOAD:   cls = OP_LOAD;
            OPC_STORE:  cls = OP_STORE;
            OPC_BRANCH: cls = OP_BRANCH;
            OPC_JAL:    cls = OP_JAL;
            OPC_LUI:    cls = OP_LUI;
            default:    cls = OP_ILLEGAL;
        endcase
        return cls;
    endfunction

    // Stores and branches carry no destination since bits 11..7 are immediate
    function automatic reg_idx_t dest_reg(input instr_word_t word, input op_class_e cls);
        reg_idx_t rd;
        if (cls == OP_STORE || cls == OP_BRANCH) begin
            rd = '0;
        end else begin
            rd = word[11:7];
        end
        return rd;
    endfunction

    // Take in order; a slot goes only if every older one goes too
    always_comb begin : accept_prefix
        logic take;
        take = !flush_i;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            take          = take && pop.slots[i].valid && (int'(dec_slots_i) > i);
            pop.accept[i] = take;
        end
    end

    always_comb begin : classify_slots
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            nxt[i].valid = pop.accept[i];
            nxt[i].pc    = pop.slots[i].pc;
            nxt[i].op    = classify(pop.slots[i].word[6:0]);
            nxt[i].rd    = dest_reg(pop.slots[i].word, nxt[i].op);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DECODE_WIDTH; i++) begin
                dec_q[i] <= '0;
            end
        end else if (flush_i) begin
            for (int i = 0; i < DECODE_WIDTH; i++) begin
                dec_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < DECODE_WIDTH; i++) begin
                dec_q[i] <= nxt[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            dec_valid_o[i] = dec_q[i].valid;
            dec_pc_o[i]    = dec_q[i].pc;
            dec_op_o[i]    = dec_q[i].op;
            dec_rd_o[i]    = dec_q[i].rd;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ibuf_top.sv
`timescale 1ns/1ps
`default_nettype none

module ibuf_top
    import pipe_cfg_pkg::*;
    import instr_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,

    // Instruction memory
    output logic [XLEN-1:0]                     imem_addr_o,
    input  logic [FETCH_WIDTH-1:0][XLEN-1:0]    imem_rdata_i,
    input  logic                                imem_valid_i,

    // Backend redirect
    input  logic                                redirect_i,
    input  logic [XLEN-1:0]                     redirect_pc_i,

    // Decode side
    input  logic [$clog2(DECODE_WIDTH+1)-1:0]   dec_slots_i,
    output logic [DECODE_WIDTH-1:0]             dec_valid_o,
    output logic [DECODE_WIDTH-1:0][XLEN-1:0]   dec_pc_o,
    output op_class_e [DECODE_WIDTH-1:0]        dec_op_o,
    output logic [DECODE_WIDTH-1:0][4:0]        dec_rd_o
);

    // Fetch to buffer
    fetch_slot_if push_bus ();

    // Buffer to decoder
    fetch_slot_if pop_bus ();

    instr_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .imem_valid_i  (imem_valid_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .push          (push_bus)
    );

    instr_buffer u_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (push_bus),
        .pop   (pop_bus)
    );

    // Decoder flush arrives through the buffer's forwarded copy
    instr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .pop         (pop_bus),
        .flush_i     (pop_bus.flush),
        .dec_slots_i (dec_slots_i),
        .dec_valid_o (dec_valid_o),
        .dec_pc_o    (dec_pc_o),
        .dec_op_o    (dec_op_o),
        .dec_rd_o    (dec_rd_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Brief high level first so the flops see a falling reset edge
    initial begin
        rst_n_o = 1'b1;
        #1;
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_ibuf_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ibuf_top
    import pipe_cfg_pkg::*;
    import instr_pkg::*;
();

    localparam int MAX_WORDS = 64;
    localparam int MAX_REDIR = 4;
    localparam int VEC_DEPTH = 256;
    localparam int CYCLES_PER_WORD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int HOLD_START = 30;
    localparam int HOLD_LEN = 30;
    localparam int FREEZE_AT = 20;

    logic clk;
    logic rst_n;
    logic [XLEN-1:0] imem_addr_o;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] imem_rdata_i;
    logic imem_valid_i;
    logic redirect_i;
    logic [XLEN-1:0] redirect_pc_i;
    logic [1:0] dec_slots_i;
    logic [DECODE_WIDTH-1:0] dec_valid_o;
    logic [DECODE_WIDTH-1:0][XLEN-1:0] dec_pc_o;
    op_class_e [DECODE_WIDTH-1:0] dec_op_o;
    logic [DECODE_WIDTH-1:0][4:0] dec_rd_o;

    logic [XLEN-1:0] vec_mem [VEC_DEPTH];
    logic [XLEN-1:0] prog_word [MAX_WORDS];
    logic [2:0] prog_cls [MAX_WORDS];
    logic [4:0] prog_rd [MAX_WORDS];
    logic [XLEN-1:0] redir_cycle [MAX_REDIR];
    logic [XLEN-1:0] redir_pc [MAX_REDIR];
    int n_words = 0;
    int n_redir = 0;
    logic loaded = 1'b0;
    logic done = 1'b0;
    logic [15:0] lfsr = 16'd43108;
    int cyc = 0;
    logic hold_active = 1'b0;
    int hold_cnt = 0;
    logic [XLEN-1:0] frozen_addr = '0;
    logic [XLEN-1:0] exp_pc = RESET_PC;
    int redirs_seen = 0;
    logic [1:0] prev_slots = 2'd0;

    tb_clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    ibuf_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .imem_valid_i  (imem_valid_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .dec_slots_i   (dec_slots_i),
        .dec_valid_o   (dec_valid_o),
        .dec_pc_o      (dec_pc_o),
        .dec_op_o      (dec_op_o),
        .dec_rd_o      (dec_rd_o)
    );

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
        stop_on_failure();
    endtask

    task automatic condition_failed(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stop_on_failure();
    endtask

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic load_vectors();
        int base;
        $readmemh("tests/ibuf_vectors.txt", vec_mem);
        n_words = int'(vec_mem[0]);
        assert (n_words > 0 && n_words <= MAX_WORDS)
            else condition_failed("program word count in vector file is out of range");
        for (int i = 0; i < n_words; i++) begin
            prog_word[i] = vec_mem[1 + 3 * i];
            prog_cls[i]  = vec_mem[2 + 3 * i][2:0];
            prog_rd[i]   = vec_mem[3 + 3 * i][4:0];
        end
        base = 1 + 3 * n_words;
        n_redir = int'(vec_mem[base]);
        assert (n_redir <= MAX_REDIR)
            else condition_failed("redirect count in vector file is out of range");
        for (int k = 0; k < n_redir; k++) begin
            redir_cycle[k] = vec_mem[base + 1 + 2 * k];
            redir_pc[k]    = vec_mem[base + 2 + 2 * k];
        end
        loaded = 1'b1;
    endtask

    // Memory model returning program words in range and an address-derived fill past the end
    always_comb begin : imem_model
        logic [XLEN-1:0] a;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            a = imem_addr_o + XLEN'(4 * i);
            if (a < XLEN'(4 * n_words)) begin
                imem_rdata_i[i] = prog_word[a[7:2]];
            end else begin
                imem_rdata_i[i] = a ^ 32'h9E37_79B9;
            end
        end
    end

    always @(posedge clk) begin : drive_inputs
        logic b0;
        logic b1;
        if (rst_n && !done) begin
            take_bit(b0);
            take_bit(b1);
            imem_valid_i <= b0 | b1;
            if (cyc >= HOLD_START && cyc < HOLD_START + HOLD_LEN) begin
                hold_active <= 1'b1;
                dec_slots_i <= 2'd0;
            end else begin
                take_bit(b0);
                take_bit(b1);
                hold_active <= 1'b0;
                dec_slots_i <= ({b1, b0} == 2'd3) ? 2'd2 : {b1, b0};
            end
            redirect_i <= 1'b0;
            for (int k = 0; k < n_redir; k++) begin
                if (XLEN'(cyc) == redir_cycle[k]) begin
                    redirect_i    <= 1'b1;
                    redirect_pc_i <= redir_pc[k];
                end
            end
            cyc <= cyc + 1;
        end
    end

    always @(negedge clk) begin : check_outputs
        int idx;
        if (rst_n && !done) begin
            assert (!(dec_valid_o[1] && !dec_valid_o[0]))
                else condition_failed("slot 1 valid while slot 0 is empty");
            assert (2'(dec_valid_o[0]) + 2'(dec_valid_o[1]) <= prev_slots)
                else value_mismatch("dec_valid_o", 32'(dec_valid_o), 32'(prev_slots));
            for (int i = 0; i < DECODE_WIDTH; i++) begin
                if (dec_valid_o[i] && !done) begin
                    idx = int'(exp_pc >> 2);
                    assert (dec_pc_o[i] == exp_pc)
                        else value_mismatch($sformatf("dec_pc_o[%0d]", i), dec_pc_o[i], exp_pc);
                    if (idx < n_words) begin
                        assert (3'(dec_op_o[i]) == prog_cls[idx])
                            else value_mismatch($sformatf("dec_op_o[%0d]", i),
                                                32'(dec_op_o[i]), 32'(prog_cls[idx]));
                        assert (dec_rd_o[i] == prog_rd[idx])
                            else value_mismatch($sformatf("dec_rd_o[%0d]", i),
                                                32'(dec_rd_o[i]), 32'(prog_rd[idx]));
                        if (idx == n_words - 1 && redirs_seen == n_redir) begin
                            done = 1'b1;
                        end
                    end
                    exp_pc = exp_pc + 32'd4;
                end
            end
            // Back-pressure window
            if (hold_active) begin
                hold_cnt = hold_cnt + 1;
                if (hold_cnt > 1) begin
                    assert (dec_valid_o == '0)
                        else condition_failed("decoded output valid while downstream takes none");
                end
                if (hold_cnt == FREEZE_AT) begin
                    frozen_addr = imem_addr_o;
                end else if (hold_cnt > FREEZE_AT) begin
                    assert (imem_addr_o == frozen_addr)
                        else value_mismatch("imem_addr_o", imem_addr_o, frozen_addr);
                end
            end
            // Outputs seen this cycle are still on the old path
            if (redirect_i) begin
                exp_pc = redirect_pc_i;
                redirs_seen = redirs_seen + 1;
            end
            prev_slots = dec_slots_i;
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (n_words * CYCLES_PER_WORD + RESET_CYCLES) @(posedge clk);
        $display("Timeout: the decoded stream did not reach the last program word in time");
        $display("Test failed");
        $fatal(1);
    end

    initial begin : run_test
        imem_valid_i  = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        dec_slots_i   = 2'd0;
        load_vectors();
        @(negedge clk);
        assert (dec_valid_o == '0)
            else value_mismatch("dec_valid_o", 32'(dec_valid_o), 32'd0);
        assert (imem_addr_o == RESET_PC)
            else value_mismatch("imem_addr_o", imem_addr_o, RESET_PC);
        wait (done);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/ibuf_vectors.txt
// Word count, then per word: instruction, class (0 ALU .. 7 ILLEGAL), rd
// Then redirect count, then per redirect: cycle after reset, target PC
00000014
00500093 1 01
00108133 0 02
00012183 2 03
00312223 3 00
00208463 4 00
010000EF 5 01
123452B7 6 05
FFFFFFFF 7 1F
00001317 7 06
FFF0C393 1 07
40110433 0 08
0081C483 2 09
009000A3 3 00
FE041EE3 4 00
FF9FF06F 5 00
FFFFFFB7 6 1F
00000000 7 00
00351513 1 0A
009565B3 0 0B
0000000F 7 00
00000002
0000000C 00000030
00000046 00000010

//--- ibuf_core.f
rtl/pipe_cfg_pkg.sv
rtl/instr_pkg.sv
rtl/fetch_slot_if.sv
rtl/instr_fetch.sv
rtl/instr_buffer.sv
rtl/instr_decode.sv
rtl/ibuf_top.sv
tests/tb_clock_gen.sv
tests/tb_ibuf_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ibuf_top \
    -f ibuf_core.f \
    -o tb_ibuf_top

./obj_dir/tb_ibuf_top
